/* hdl/scroll_pkg.sv */
package scroll_pkg;

    // Raster and plane coordinates, 512 wide planes
    typedef logic [8:0] coord_t;
    typedef logic [8:0] scroll_t;    // Scroll offset, wraps at 512

    // Map ROM, 32x32 tiles, row in the upper half
    typedef logic [9:0]  map_addr_t;
    typedef logic [15:0] map_word_t;  // prio, hflip, pal[3:0], code[9:0]

    // Tile ROM, code then pixel row then column quad
    typedef logic [15:0] tile_addr_t;
    typedef logic [15:0] tile_word_t; // Lowest nibble is leftmost

    // Layer bit, palette, colour
    typedef logic [8:0] pal_idx_t;

    // Map word fields
    localparam int MAP_CODE_LSB = 0;
    localparam int MAP_PAL_LSB  = 10;
    localparam int MAP_HFLIP    = 14;
    localparam int MAP_PRIO     = 15;

    // APB register map
    localparam logic [4:0] REG_BG_HPOS  = 5'h00;
    localparam logic [4:0] REG_BG_VPOS  = 5'h04;
    localparam logic [4:0] REG_FG_HPOS  = 5'h08;
    localparam logic [4:0] REG_FG_VPOS  = 5'h0C;
    localparam logic [4:0] REG_CTRL     = 5'h10; // bg_en, fg_en, flip
    localparam logic [4:0] REG_BACKDROP = 5'h14;

    // CTRL bits
    localparam int CTRL_BG_EN = 0;
    localparam int CTRL_FG_EN = 1;
    localparam int CTRL_FLIP  = 2;

endpackage

/* hdl/raster_counter.sv */
`timescale 1ns/1ps

module raster_counter #(
    parameter int H_TOTAL   = 320,
    parameter int H_VISIBLE = 256,
    parameter int V_TOTAL   = 262,
    parameter int V_VISIBLE = 224
) (
    input  logic                clk,
    input  logic                rst_n,
    output scroll_pkg::coord_t  h,
    output scroll_pkg::coord_t  v,
    output logic                visible,
    output logic                frame_start
);

    localparam scroll_pkg::coord_t H_LAST = scroll_pkg::coord_t'(H_TOTAL - 1);
    localparam scroll_pkg::coord_t V_LAST = scroll_pkg::coord_t'(V_TOTAL - 1);
    localparam scroll_pkg::coord_t H_VIS  = scroll_pkg::coord_t'(H_VISIBLE);
    localparam scroll_pkg::coord_t V_VIS  = scroll_pkg::coord_t'(V_VISIBLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (h == H_LAST) begin
            h <= '0;
            v <= (v == V_LAST) ? '0 : v + 1'b1; // Line wrap
        end else begin
            h <= h + 1'b1;
        end
    end

    assign visible = (h < H_VIS) && (v < V_VIS);

    // High on the last count, shadows load as the raster lands on (0, 0)
    assign frame_start = (h == H_LAST) && (v == V_LAST);

endmodule

/* hdl/scroll_apb_regs.sv */
`timescale 1ns/1ps

module scroll_apb_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [4:0]            paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  frame_start,
    output scroll_pkg::scroll_t   bg_hpos,
    output scroll_pkg::scroll_t   bg_vpos,
    output scroll_pkg::scroll_t   fg_hpos,
    output scroll_pkg::scroll_t   fg_vpos,
    output logic                  bg_en,
    output logic                  fg_en,
    output logic                  flip,
    output scroll_pkg::pal_idx_t  backdrop
);

    // Live copies, CPU side
    scroll_pkg::scroll_t  bg_hpos_r, bg_vpos_r, fg_hpos_r, fg_vpos_r;
    scroll_pkg::pal_idx_t backdrop_r;
    logic [2:0]           ctrl_r;

    logic        addr_ok;
    logic [31:0] rdata;
    logic        access;

    assign access  = psel & penable;
    assign pready  = access;            // No wait states
    assign pslverr = access & ~addr_ok;

    // Offset decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (paddr)
            scroll_pkg::REG_BG_HPOS:  rdata[8:0] = bg_hpos_r;
            scroll_pkg::REG_BG_VPOS:  rdata[8:0] = bg_vpos_r;
            scroll_pkg::REG_FG_HPOS:  rdata[8:0] = fg_hpos_r;
            scroll_pkg::REG_FG_VPOS:  rdata[8:0] = fg_vpos_r;
            scroll_pkg::REG_CTRL:     rdata[2:0] = ctrl_r;
            scroll_pkg::REG_BACKDROP: rdata[8:0] = backdrop_r;
            default:                  addr_ok    = 1'b0; // Holes and unaligned
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bg_hpos_r  <= '0;
            bg_vpos_r  <= '0;
            fg_hpos_r  <= '0;
            fg_vpos_r  <= '0;
            ctrl_r     <= '0;
            backdrop_r <= '0;
            prdata     <= '0;
        end else begin
            if (psel && !penable && !pwrite)
                prdata <= rdata; // Sampled in setup, held through access
            if (access && pwrite && addr_ok) begin
                case (paddr)
                    scroll_pkg::REG_BG_HPOS:  bg_hpos_r  <= pwdata[8:0];
                    scroll_pkg::REG_BG_VPOS:  bg_vpos_r  <= pwdata[8:0];
                    scroll_pkg::REG_FG_HPOS:  fg_hpos_r  <= pwdata[8:0];
                    scroll_pkg::REG_FG_VPOS:  fg_vpos_r  <= pwdata[8:0];
                    scroll_pkg::REG_CTRL:     ctrl_r     <= pwdata[2:0];
                    default:                  backdrop_r <= pwdata[8:0];
                endcase
            end
        end
    end

    // Shadows seen by the video path, frame boundary only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bg_hpos  <= '0;
            bg_vpos  <= '0;
            fg_hpos  <= '0;
            fg_vpos  <= '0;
            bg_en    <= 1'b0;
            fg_en    <= 1'b0;
            flip     <= 1'b0;
            backdrop <= '0;
        end else if (frame_start) begin
            bg_hpos  <= bg_hpos_r;
            bg_vpos  <= bg_vpos_r;
            fg_hpos  <= fg_hpos_r;
            fg_vpos  <= fg_vpos_r;
            bg_en    <= ctrl_r[scroll_pkg::CTRL_BG_EN];
            fg_en    <= ctrl_r[scroll_pkg::CTRL_FG_EN];
            flip     <= ctrl_r[scroll_pkg::CTRL_FLIP];
            backdrop <= backdrop_r;
        end
    end

endmodule

/* hdl/scroll_map_addr.sv */
`timescale 1ns/1ps

module scroll_map_addr #(
    parameter int H_VISIBLE = 256,
    parameter int V_VISIBLE = 224
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  scroll_pkg::coord_t     h,
    input  scroll_pkg::coord_t     v,
    input  logic                   flip,
    input  scroll_pkg::scroll_t    hpos,
    input  scroll_pkg::scroll_t    vpos,
    output scroll_pkg::map_addr_t  map_addr,
    output logic [3:0]             col_lo,
    output logic [3:0]             row_lo
);

    // Mirror points for the flipped screen
    localparam scroll_pkg::coord_t X_MAX = scroll_pkg::coord_t'(H_VISIBLE - 1);
    localparam scroll_pkg::coord_t Y_MAX = scroll_pkg::coord_t'(V_VISIBLE - 1);

    scroll_pkg::coord_t sx, sy; // Screen position after flip
    scroll_pkg::coord_t px, py; // Plane position

    always_comb begin
        sx = flip ? X_MAX - h : h;
        sy = flip ? Y_MAX - v : v;
        px = sx + hpos;          // 9 bit sum, plane wraps at 512
        py = sy + vpos;
    end

    // Edge 1, map ROM address plus in-tile bits for later stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_addr <= '0;
            col_lo   <= '0;
            row_lo   <= '0;
        end else begin
            map_addr <= {py[8:4], px[8:4]}; // Row then column
            col_lo   <= px[3:0];
            row_lo   <= py[3:0];
        end
    end

endmodule

/* hdl/scroll_layer.sv */
`timescale 1ns/1ps

module scroll_layer #(
    parameter int H_VISIBLE = 256,
    parameter int V_VISIBLE = 224
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  scroll_pkg::coord_t      h,
    input  scroll_pkg::coord_t      v,
    input  logic                    flip,
    input  scroll_pkg::scroll_t     hpos,
    input  scroll_pkg::scroll_t     vpos,
    output scroll_pkg::map_addr_t   map_addr,
    input  scroll_pkg::map_word_t   map_data,
    output scroll_pkg::tile_addr_t  tile_addr,
    input  scroll_pkg::tile_word_t  tile_data,
    output logic [3:0]              pal,
    output logic [3:0]              color,
    output logic                    prio
);

    logic [3:0] col_lo, row_lo;
    logic [3:0] col_d, row_d;   // Aligned with map_data
    logic [3:0] col_c;          // Column after tile flip
    logic [1:0] sel_q, sel_q2;  // Nibble select, edges 3 and 4
    logic [3:0] pal_q, pal_q2;
    logic       prio_q, prio_q2;

    scroll_map_addr #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE)
    ) scroll_map_addr_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .h        (h),
        .v        (v),
        .flip     (flip),
        .hpos     (hpos),
        .vpos     (vpos),
        .map_addr (map_addr),
        .col_lo   (col_lo),
        .row_lo   (row_lo)
    );

    assign col_c = col_d ^ {4{map_data[scroll_pkg::MAP_HFLIP]}};

    always_ff @(posedge clk) begin
        col_d <= col_lo; // Edge 2, waits for the map ROM
        row_d <= row_lo;
        // Edge 3, decode map word
        tile_addr <= {map_data[scroll_pkg::MAP_CODE_LSB +: 10], row_d, col_c[3:2]};
        sel_q     <= col_c[1:0];
        pal_q     <= map_data[scroll_pkg::MAP_PAL_LSB +: 4];
        prio_q    <= map_data[scroll_pkg::MAP_PRIO];
        // Edge 4, ride along with the tile ROM read
        sel_q2  <= sel_q;
        pal_q2  <= pal_q;
        prio_q2 <= prio_q;
    end

    // Edge 5, pixel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            color <= '0; // Transparent
            pal   <= '0;
            prio  <= 1'b0;
        end else begin
            color <= tile_data[{sel_q2, 2'b00} +: 4];
            pal   <= pal_q2;
            prio  <= prio_q2;
        end
    end

endmodule

/* hdl/layer_mixer.sv */
`timescale 1ns/1ps

module layer_mixer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bg_en,
    input  logic                  fg_en,
    input  logic [3:0]            bg_pal,
    input  logic [3:0]            bg_color,
    input  logic                  bg_prio,
    input  logic [3:0]            fg_pal,
    input  logic [3:0]            fg_color,
    input  scroll_pkg::pal_idx_t  backdrop,
    input  scroll_pkg::coord_t    h,
    input  scroll_pkg::coord_t    v,
    input  logic                  visible,
    output scroll_pkg::pal_idx_t  pix_idx,
    output logic                  pix_valid,
    output scroll_pkg::coord_t    pix_x,
    output scroll_pkg::coord_t    pix_y
);

    localparam int DLY = 5; // Counter to plane pixel

    scroll_pkg::coord_t h_d [DLY];
    scroll_pkg::coord_t v_d [DLY];
    logic [DLY-1:0]     vis_d;

    logic bg_op, fg_op; // Enabled and not colour 0
    scroll_pkg::pal_idx_t mix;

    assign bg_op = bg_en && (bg_color != 4'd0);
    assign fg_op = fg_en && (fg_color != 4'd0);

    always_comb begin
        if (bg_op && bg_prio)
            mix = {1'b0, bg_pal, bg_color};  // Priority tile over fg
        else if (fg_op)
            mix = {1'b1, fg_pal, fg_color};
        else if (bg_op)
            mix = {1'b0, bg_pal, bg_color};
        else
            mix = backdrop;
    end

    // Raster position follows the planes
    always_ff @(posedge clk) begin
        h_d[0] <= h;
        v_d[0] <= v;
        for (int i = 1; i < DLY; i++) begin
            h_d[i] <= h_d[i-1];
            v_d[i] <= v_d[i-1];
        end
        pix_x <= h_d[DLY-1];
        pix_y <= v_d[DLY-1];
    end

    // Edge 6
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vis_d     <= '0;
            pix_valid <= 1'b0;
            pix_idx   <= '0;
        end else begin
            vis_d     <= {vis_d[DLY-2:0], visible};
            pix_valid <= vis_d[DLY-1];
            pix_idx   <= mix;
        end
    end

endmodule

/* hdl/scroll_video_top.sv */
`timescale 1ns/1ps

module scroll_video_top #(
    parameter int H_TOTAL   = 320,
    parameter int H_VISIBLE = 256,
    parameter int V_TOTAL   = 262,
    parameter int V_VISIBLE = 224
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output scroll_pkg::map_addr_t   bg_map_addr,
    input  scroll_pkg::map_word_t   bg_map_data,
    output scroll_pkg::tile_addr_t  bg_tile_addr,
    input  scroll_pkg::tile_word_t  bg_tile_data,
    output scroll_pkg::map_addr_t   fg_map_addr,
    input  scroll_pkg::map_word_t   fg_map_data,
    output scroll_pkg::tile_addr_t  fg_tile_addr,
    input  scroll_pkg::tile_word_t  fg_tile_data,
    output scroll_pkg::pal_idx_t    pix_idx,
    output logic                    pix_valid,
    output scroll_pkg::coord_t      pix_x,
    output scroll_pkg::coord_t      pix_y
);

    scroll_pkg::coord_t   h, v;
    logic                 visible, frame_start;
    scroll_pkg::scroll_t  bg_hpos, bg_vpos, fg_hpos, fg_vpos;
    logic                 bg_en, fg_en, flip;
    scroll_pkg::pal_idx_t backdrop;
    logic [3:0]           bg_pal, bg_color, fg_pal, fg_color;
    logic                 bg_prio;

    raster_counter #(
        .H_TOTAL   (H_TOTAL),
        .H_VISIBLE (H_VISIBLE),
        .V_TOTAL   (V_TOTAL),
        .V_VISIBLE (V_VISIBLE)
    ) raster_counter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .h           (h),
        .v           (v),
        .visible     (visible),
        .frame_start (frame_start)
    );

    scroll_apb_regs scroll_apb_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .frame_start (frame_start),
        .bg_hpos     (bg_hpos),
        .bg_vpos     (bg_vpos),
        .fg_hpos     (fg_hpos),
        .fg_vpos     (fg_vpos),
        .bg_en       (bg_en),
        .fg_en       (fg_en),
        .flip        (flip),
        .backdrop    (backdrop)
    );

    // Background plane
    scroll_layer #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE)
    ) bg_layer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .h         (h),
        .v         (v),
        .flip      (flip),
        .hpos      (bg_hpos),
        .vpos      (bg_vpos),
        .map_addr  (bg_map_addr),
        .map_data  (bg_map_data),
        .tile_addr (bg_tile_addr),
        .tile_data (bg_tile_data),
        .pal       (bg_pal),
        .color     (bg_color),
        .prio      (bg_prio)
    );

    // Foreground plane, its priority bit has no effect in the mixer
    scroll_layer #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE)
    ) fg_layer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .h         (h),
        .v         (v),
        .flip      (flip),
        .hpos      (fg_hpos),
        .vpos      (fg_vpos),
        .map_addr  (fg_map_addr),
        .map_data  (fg_map_data),
        .tile_addr (fg_tile_addr),
        .tile_data (fg_tile_data),
        .pal       (fg_pal),
        .color     (fg_color),
        .prio      ()
    );

    layer_mixer layer_mixer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .bg_en     (bg_en),
        .fg_en     (fg_en),
        .bg_pal    (bg_pal),
        .bg_color  (bg_color),
        .bg_prio   (bg_prio),
        .fg_pal    (fg_pal),
        .fg_color  (fg_color),
        .backdrop  (backdrop),
        .h         (h),
        .v         (v),
        .visible   (visible),
        .pix_idx   (pix_idx),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix_y     (pix_y)
    );

endmodule

/* include/scroll_rom_model.svh */
`ifndef SCROLL_ROM_MODEL_SVH
`define SCROLL_ROM_MODEL_SVH

// Integer mixer behind both ROM models
function automatic logic [31:0] rom_hash(input logic [31:0] x, input logic [31:0] salt);
    logic [31:0] r;
    r = x ^ salt;
    r = r * 32'h9e3779b1;
    r = r ^ (r >> 15);
    r = r * 32'h85ebca6b;
    r = r ^ (r >> 13);
    return r;
endfunction

// Map word for plane fg (0 bg, 1 fg)
function automatic scroll_pkg::map_word_t map_rom_word(input logic fg,
                                                       input scroll_pkg::map_addr_t a);
    logic [31:0] r;
    r = rom_hash({22'd0, a}, fg ? 32'h5bd1e995 : 32'h27d4eb2f);
    return r[15:0]; // Code, palette, hflip and prio all random
endfunction

// Tile word, about a quarter of the pixels forced transparent
function automatic scroll_pkg::tile_word_t tile_rom_word(input logic fg,
                                                         input scroll_pkg::tile_addr_t a);
    logic [31:0] r;
    scroll_pkg::tile_word_t w;
    r = rom_hash({16'd0, a}, fg ? 32'hc2b2ae35 : 32'h165667b1);
    w = r[15:0];
    for (int i = 0; i < 4; i++) begin
        if (r[16 + 2*i +: 2] == 2'd0)
            w[4*i +: 4] = 4'd0;
    end
    return w;
endfunction

`endif

/* verification/scroll_tb.sv */
`timescale 1ns/1ps

module scroll_tb;

    localparam int  H_TOTAL      = 80;
    localparam int  H_VISIBLE    = 64;
    localparam int  V_TOTAL      = 56;
    localparam int  V_VISIBLE    = 48;
    localparam int  FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int  TOTAL_FRAMES = 32;    // Frames used by all tests together
    localparam int  PIPE_LAT     = 6;     // Counter to pix_idx, in clocks
    localparam real CLK_PERIOD   = 100.0;

    `include "scroll_rom_model.svh"

    logic                   clk, rst_n;
    logic [4:0]             paddr;
    logic                   psel, penable, pwrite;
    logic [31:0]            pwdata, prdata;
    logic                   pready, pslverr;
    scroll_pkg::map_addr_t  bg_map_addr, fg_map_addr;
    scroll_pkg::map_word_t  bg_map_data, fg_map_data;
    scroll_pkg::tile_addr_t bg_tile_addr, fg_tile_addr;
    scroll_pkg::tile_word_t bg_tile_data, fg_tile_data;
    scroll_pkg::pal_idx_t   pix_idx;
    logic                   pix_valid;
    scroll_pkg::coord_t     pix_x, pix_y;

    logic [8:0] live_reg [6];   // Register model, index is offset / 4
    logic [8:0] shadow_reg [6]; // What the video path uses this frame
    int         m_h, m_v;       // Raster model
    int         exp_x, exp_y;   // Raster position due on the output
    logic       exp_valid;
    scroll_pkg::map_addr_t  bg_ma_q, fg_ma_q;
    scroll_pkg::tile_addr_t bg_ta_q, fg_ta_q;

    string cur_test;
    int    errors, pix_count, tests_run, tests_failed, err_start, pix_start;

    scroll_video_top #(
        .H_TOTAL   (H_TOTAL),
        .H_VISIBLE (H_VISIBLE),
        .V_TOTAL   (V_TOTAL),
        .V_VISIBLE (V_VISIBLE)
    ) scroll_video_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .bg_map_addr  (bg_map_addr),
        .bg_map_data  (bg_map_data),
        .bg_tile_addr (bg_tile_addr),
        .bg_tile_data (bg_tile_data),
        .fg_map_addr  (fg_map_addr),
        .fg_map_data  (fg_map_data),
        .fg_tile_addr (fg_tile_addr),
        .fg_tile_data (fg_tile_data),
        .pix_idx      (pix_idx),
        .pix_valid    (pix_valid),
        .pix_x        (pix_x),
        .pix_y        (pix_y)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ROMs, address seen after edge N, data out after edge N+1
    always begin
        @(negedge clk);
        bg_ma_q = bg_map_addr;
        @(posedge clk);
        #1 bg_map_data = map_rom_word(1'b0, bg_ma_q);
    end

    always begin
        @(negedge clk);
        bg_ta_q = bg_tile_addr;
        @(posedge clk);
        #1 bg_tile_data = tile_rom_word(1'b0, bg_ta_q);
    end

    always begin
        @(negedge clk);
        fg_ma_q = fg_map_addr;
        @(posedge clk);
        #1 fg_map_data = map_rom_word(1'b1, fg_ma_q);
    end

    always begin
        @(negedge clk);
        fg_ta_q = fg_tile_addr;
        @(posedge clk);
        #1 fg_tile_data = tile_rom_word(1'b1, fg_ta_q);
    end

    // Stored value of a register, CTRL keeps three bits
    function automatic logic [8:0] reg_value(input int idx, input logic [31:0] d);
        return (idx == 4) ? {6'd0, d[2:0]} : d[8:0];
    endfunction

    function automatic logic [8:0] rnd9();
        return $urandom % 512;
    endfunction

    // Raster and register model, shadows follow the live set at the last count
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_h <= 0;
            m_v <= 0;
            for (int i = 0; i < 6; i++) begin
                live_reg[i]   <= '0;
                shadow_reg[i] <= '0;
            end
        end else begin
            if (m_h == H_TOTAL - 1) begin
                m_h <= 0;
                m_v <= (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end else begin
                m_h <= m_h + 1;
            end
            if (psel && penable && pwrite && paddr[1:0] == 2'b00 && paddr[4:2] < 6)
                live_reg[paddr[4:2]] <= reg_value(paddr[4:2], pwdata);
            if (m_h == H_TOTAL - 1 && m_v == V_TOTAL - 1) begin
                for (int i = 0; i < 6; i++)
                    shadow_reg[i] <= live_reg[i]; // Old value if written on this edge
            end
        end
    end

    // Linear raster count on the output, the counter model PIPE_LAT clocks back
    function automatic int out_lin();
        int lin;
        lin = m_v * H_TOTAL + m_h - PIPE_LAT;
        return (lin < 0) ? lin + FRAME_CYCLES : lin;
    endfunction

    // One plane, returns prio, palette, colour
    function automatic logic [8:0] plane_pixel(input logic fg, input scroll_pkg::coord_t x,
                                               input scroll_pkg::coord_t y,
                                               input logic [8:0] hpos, input logic [8:0] vpos,
                                               input logic flip);
        int                     sx, sy;
        logic [8:0]             px, py;
        logic [3:0]             c;
        scroll_pkg::map_word_t  mw;
        scroll_pkg::tile_word_t tw;
        sx = flip ? H_VISIBLE - 1 - int'(x) : int'(x);
        sy = flip ? V_VISIBLE - 1 - int'(y) : int'(y);
        px = (sx + hpos) % 512;
        py = (sy + vpos) % 512;
        mw = map_rom_word(fg, {py[8:4], px[8:4]});
        c  = px[3:0] ^ {4{mw[14]}};   // Tile flip
        tw = tile_rom_word(fg, {mw[9:0], py[3:0], c[3:2]});
        return {mw[15], mw[13:10], tw[4 * c[1:0] +: 4]};
    endfunction

    function automatic scroll_pkg::pal_idx_t expected_pixel(input scroll_pkg::coord_t x,
                                                            input scroll_pkg::coord_t y);
        logic [8:0] b, f;
        logic [2:0] ctrl;
        logic       bg_op, fg_op;
        ctrl  = shadow_reg[4][2:0];
        b     = plane_pixel(1'b0, x, y, shadow_reg[0], shadow_reg[1], ctrl[2]);
        f     = plane_pixel(1'b1, x, y, shadow_reg[2], shadow_reg[3], ctrl[2]);
        bg_op = ctrl[0] && (b[3:0] != 4'd0);
        fg_op = ctrl[1] && (f[3:0] != 4'd0);
        if (bg_op && b[8])
            return {1'b0, b[7:0]};
        else if (fg_op)
            return {1'b1, f[7:0]};
        else if (bg_op)
            return {1'b0, b[7:0]};
        return shadow_reg[5];   // Backdrop
    endfunction

    task automatic check_pix(input scroll_pkg::coord_t x, input scroll_pkg::coord_t y,
                             input scroll_pkg::pal_idx_t exp, input scroll_pkg::pal_idx_t act);
        if (act !== exp) begin
            $display("mismatch %s pixel (%0d,%0d): expected %h actual %h",
                     cur_test, x, y, exp, act);
            errors++;
        end
    endtask

    task automatic check_pos(input string axis, input scroll_pkg::coord_t exp,
                             input scroll_pkg::coord_t act);
        if (act !== exp) begin
            $display("mismatch %s pix_%s: expected %0d actual %0d", cur_test, axis, exp, act);
            errors++;
        end
    endtask

    task automatic check_valid(input int x, input int y, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s pix_valid at (%0d,%0d): expected %b actual %b",
                     cur_test, x, y, exp, act);
            errors++;
        end
    endtask

    task automatic check_apb(input logic [4:0] addr, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s prdata @%h: expected %h actual %h", cur_test, addr, exp, act);
            errors++;
        end
    endtask

    task automatic check_slverr(input logic [4:0] addr, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s pslverr @%h: expected %b actual %b", cur_test, addr, exp, act);
            errors++;
        end
    endtask

    // Setup then access, sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("%s: pready never came for offset %h", cur_test, addr);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_slverr(addr, exp_err, err);
    endtask

    task automatic apb_read(input logic [4:0] addr, input logic [31:0] exp, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rd, err);
        check_slverr(addr, exp_err, err);
        if (!exp_err)
            check_apb(addr, exp, rd);   // Data undefined on an error
    endtask

    // Returns at the falling edge where pixel (x, y) is on the output
    task automatic wait_pixel(input int x, input int y);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(pix_valid && pix_x == x && pix_y == y) && n < 2 * FRAME_CYCLES);
        if (!(pix_valid && pix_x == x && pix_y == y)) begin
            $display("%s: pixel (%0d,%0d) never appeared", cur_test, x, y);
            errors++;
        end
    endtask

    task automatic wait_frame_end();
        wait_pixel(H_VISIBLE - 1, V_VISIBLE - 1);
    endtask

    task automatic scroll_frame(input logic [2:0] ctrl, input logic [8:0] bh, input logic [8:0] bv,
                                input logic [8:0] fh, input logic [8:0] fv);
        apb_write(5'h00, {23'd0, bh}, 1'b0);
        apb_write(5'h04, {23'd0, bv}, 1'b0);
        apb_write(5'h08, {23'd0, fh}, 1'b0);
        apb_write(5'h0C, {23'd0, fv}, 1'b0);
        apb_write(5'h10, {29'd0, ctrl}, 1'b0);
        wait_frame_end();   // Lands before frame_start, next frame is checked whole
        wait_frame_end();
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = errors;
        pix_start = pix_count;
    endtask

    task automatic end_test();
        @(posedge clk);
        #1;
        tests_run++;
        if (pix_count == pix_start) begin
            $display("%s: no pixels were checked", cur_test);
            errors++;
        end
        if (errors == err_start) begin
            $display("test %s passed, %0d pixels", cur_test, pix_count - pix_start);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors", cur_test, errors - err_start);
        end
    endtask

    // Output flag and position against the raster model, visible pixels against the reference
    always @(negedge clk) begin
        if (rst_n) begin
            exp_x     = out_lin() % H_TOTAL;
            exp_y     = out_lin() / H_TOTAL;
            exp_valid = (exp_x < H_VISIBLE) && (exp_y < V_VISIBLE);
            check_valid(exp_x, exp_y, exp_valid, pix_valid);
            if (exp_valid) begin
                check_pos("x", scroll_pkg::coord_t'(exp_x), pix_x);
                check_pos("y", scroll_pkg::coord_t'(exp_y), pix_y);
            end
            if (pix_valid) begin
                check_pix(pix_x, pix_y, expected_pixel(pix_x, pix_y), pix_idx);
                pix_count++;
            end
        end
    end

    initial begin
        #(2.0 * TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d frames, run stopped", 2 * TOTAL_FRAMES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int                   seed_ret;
        logic [31:0]          vals [6];
        scroll_pkg::pal_idx_t bd;
        seed_ret     = $urandom(32'hf046db3b);
        clk          = 1'b0;
        rst_n        = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        bg_map_data  = '0;
        bg_tile_data = '0;
        fg_map_data  = '0;
        fg_tile_data = '0;
        errors       = 0;
        pix_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset";
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        begin_test("backdrop_after_reset");
        wait_frame_end();   // Both planes off, backdrop 0
        bd = rnd9();
        apb_write(5'h14, {23'd0, bd}, 1'b0);
        wait_frame_end();
        wait_frame_end();
        check_pix(pix_x, pix_y, bd, pix_idx);
        end_test();

        begin_test("regs_rw");
        for (int i = 0; i < 6; i++) begin
            vals[i] = $urandom;
            apb_write(5'(4 * i), vals[i], 1'b0);
        end
        for (int i = 0; i < 6; i++)
            apb_read(5'(4 * i), {23'd0, reg_value(i, vals[i])}, 1'b0);
        apb_read(5'h18, 32'd0, 1'b1);
        apb_write(5'h1C, $urandom, 1'b1);
        apb_write(5'h02, $urandom, 1'b1);  // Unaligned
        apb_write(5'h16, $urandom, 1'b1);
        for (int i = 0; i < 6; i++)
            apb_read(5'(4 * i), {23'd0, reg_value(i, vals[i])}, 1'b0);
        wait_frame_end();
        end_test();

        begin_test("bg_scroll");
        scroll_frame(3'b001, 9'd500, 9'd490, rnd9(), rnd9()); // Wraps on both axes
        repeat (3) scroll_frame(3'b001, rnd9(), rnd9(), rnd9(), rnd9());
        end_test();

        begin_test("two_planes");
        repeat (4) scroll_frame(3'b011, rnd9(), rnd9(), rnd9(), rnd9());
        end_test();

        begin_test("flip");
        scroll_frame(3'b101, 9'd505, 9'd500, 9'd0, 9'd0);
        repeat (3) scroll_frame(3'b111, rnd9(), rnd9(), rnd9(), rnd9());
        end_test();

        begin_test("mid_frame_write");
        scroll_frame(3'b011, rnd9(), rnd9(), rnd9(), rnd9());
        wait_pixel(H_VISIBLE / 2, V_VISIBLE / 2);
        apb_write(5'h00, {23'd0, rnd9()}, 1'b0);
        apb_write(5'h0C, {23'd0, rnd9()}, 1'b0);
        apb_write(5'h10, 32'd7, 1'b0);
        apb_write(5'h14, {23'd0, rnd9()}, 1'b0);
        wait_frame_end();   // Rest of this frame on the old set
        wait_frame_end();
        end_test();

        $display("tests %0d, failed %0d, errors %0d, pixels checked %0d",
                 tests_run, tests_failed, errors, pix_count);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* project.f */
+incdir+include
hdl/scroll_pkg.sv
hdl/raster_counter.sv
hdl/scroll_apb_regs.sv
hdl/scroll_map_addr.sv
hdl/scroll_layer.sv
hdl/layer_mixer.sv
hdl/scroll_video_top.sv
verification/scroll_tb.sv
